// ==== source/fifo_bridge_pkg.sv ====
// shared widths, register map and encodings for the stream bridge.
// one clock domain only; register writes have no read-back path.
package fifo_bridge_pkg;

   ////////////////////////////////////////////////////////////
   // widths and register map
   ////////////////////////////////////////////////////////////
   localparam int data_width = 64;   // stream and register word.
   localparam int addr_width = 13;   // register address bits.

   localparam logic [addr_width-1:0] addr_ctrl  = 13'd0;   // led, mode, start.
   localparam logic [addr_width-1:0] addr_burst = 13'd1;   // seed and length.

   ////////////////////////////////////////////////////////////
   // modes and controller states
   ////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      mode_idle  = 2'd0,   // nothing goes to the host.
      mode_loop  = 2'd1,   // host words echoed back.
      mode_burst = 2'd2    // counting sequence on start.
   } mode_t;

   typedef enum logic [1:0] {
      st_idle  = 2'd0,
      st_loop  = 2'd1,
      st_burst = 2'd2,
      st_done  = 2'd3      // one cycle, raises the interrupt.
   } ctrl_state_t;

   // one host write word, read through the view that matches its address
   typedef union packed {
      struct packed {
         logic [54:0] reserved_hi;   // bits 63..9.
         logic        start;         // bit 8.
         logic [1:0]  reserved_lo;   // bits 7..6.
         mode_t       mode;          // bits 5..4.
         logic [3:0]  led;           // bits 3..0.
      } ctrl;
      struct packed {
         logic [15:0] reserved;      // bits 63..48.
         logic [15:0] length;        // bits 47..32.
         logic [31:0] seed;          // bits 31..0.
      } burst;
   } pio_word_t;

endpackage

// ==== source/pio_regs.sv ====
// host register writes; a write shows on the outputs one cycle later.
// writes to unmapped addresses are dropped.
module pio_regs
(
   input  logic                                  clock,
   input  logic                                  rst,
   input  logic                                  pio_valid,
   input  logic [fifo_bridge_pkg::addr_width-1:0] pio_address,
   input  fifo_bridge_pkg::pio_word_t            pio_data,
   output logic [3:0]                            led,
   output fifo_bridge_pkg::mode_t                mode,
   output logic                                  start,
   output logic [31:0]                           seed,
   output logic [15:0]                           length
);
   import fifo_bridge_pkg::*;

   logic ctrl_write;    // write hits the control register.
   logic burst_write;   // write hits the burst setup register.

   assign ctrl_write  = pio_valid && (pio_address == addr_ctrl);
   assign burst_write = pio_valid && (pio_address == addr_burst);

   ////////////////////////////////////////////////////////////
   // control register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         led   <= 4'h5;        // power-on pattern.
         mode  <= mode_idle;
         start <= 1'b0;
      end
      else
      begin
         start <= 1'b0;        // single pulse per write.
         if (ctrl_write)
         begin
            led   <= pio_data.ctrl.led;
            mode  <= pio_data.ctrl.mode;
            start <= pio_data.ctrl.start;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // burst setup register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         seed   <= 32'd0;
         length <= 16'd0;      // zero length blocks a burst start.
      end
      else if (burst_write)
      begin
         seed   <= pio_data.burst.seed;
         length <= pio_data.burst.length;
      end
   end

endmodule

// ==== source/stream_fifo.sv ====
// host-to-design word buffer; rx_depth must be a power of two.
// the host is trusted to send only against credits, so full never drops data in use.
module stream_fifo
#(
   parameter int rx_depth = 16
)
(
   input  logic                                  clock,
   input  logic                                  rst,
   input  logic                                  rx_valid,
   input  logic [fifo_bridge_pkg::data_width-1:0] rx_data,
   input  logic                                  fifo_read,
   output logic [fifo_bridge_pkg::data_width-1:0] fifo_data,
   output logic                                  fifo_empty,
   output logic                                  rx_credit
);
   import fifo_bridge_pkg::*;

   localparam int aw = $clog2(rx_depth);   // pointer index bits.

   logic [data_width-1:0] mem [rx_depth];
   logic [aw:0]           wr_ptr;          // extra msb tells full from empty.
   logic [aw:0]           rd_ptr;
   logic                  full;
   logic                  do_write;
   logic                  do_read;

   assign full       = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
   assign fifo_empty = (wr_ptr == rd_ptr);
   assign do_write   = rx_valid && !full;
   assign do_read    = fifo_read && !fifo_empty;

   // show-ahead read, head word is always on fifo_data
   assign fifo_data = mem[rd_ptr[aw-1:0]];

   ////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock)
   begin
      if (do_write)
      begin
         mem[wr_ptr[aw-1:0]] <= rx_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // pointers and credit return
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         rx_credit <= 1'b0;
      end
      else
      begin
         if (do_write)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         rx_credit <= do_read;   // one credit per word removed.
      end
   end

endmodule

// ==== source/word_counter.sv ====
// burst sequence source; the value is 32 bits, zero-extended on the output.
// step after the last word leaves remaining at zero and count_last low.
module word_counter
(
   input  logic                                  clock,
   input  logic                                  rst,
   input  logic                                  load,
   input  logic [31:0]                           seed,
   input  logic [15:0]                           length,
   input  logic                                  step,
   output logic [fifo_bridge_pkg::data_width-1:0] count_value,
   output logic                                  count_last
);
   import fifo_bridge_pkg::*;

   logic [31:0] value;       // next word to send.
   logic [15:0] remaining;   // words left in the burst.

   assign count_value = {{(data_width-32){1'b0}}, value};
   assign count_last  = (remaining == 16'd1);

   // sequence value
   always_ff @(posedge clock)
   begin
      if (load)
      begin
         value <= seed;
      end
      else if (step)
      begin
         value <= value + 32'd1;   // wraps at 2^32.
      end
   end

   // words remaining
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         remaining <= 16'd0;
      end
      else if (load)
      begin
         remaining <= length;
      end
      else if (step && (remaining != 16'd0))
      begin
         remaining <= remaining - 16'd1;
      end
   end

endmodule

// ==== source/stream_ctrl.sv ====
// picks the to-host word source and spends to-host credits.
// a credit is taken in the decision cycle; tx_valid follows one cycle later.
module stream_ctrl
#(
   parameter int tx_credits = 8
)
(
   input  logic                                  clock,
   input  logic                                  rst,
   input  fifo_bridge_pkg::mode_t                mode,
   input  logic                                  start,
   input  logic [15:0]                           length,
   input  logic [fifo_bridge_pkg::data_width-1:0] fifo_data,
   input  logic                                  fifo_empty,
   input  logic [fifo_bridge_pkg::data_width-1:0] count_value,
   input  logic                                  count_last,
   input  logic                                  tx_credit,
   output logic                                  fifo_read,
   output logic                                  load,
   output logic                                  step,
   output logic                                  tx_valid,
   output logic [fifo_bridge_pkg::data_width-1:0] tx_data,
   output logic                                  interrupt
);
   import fifo_bridge_pkg::*;

   localparam int cw = $clog2(tx_credits + 1);   // credit counter bits.

   ctrl_state_t state;
   ctrl_state_t state_next;
   logic [cw-1:0] credits;   // free slots in the host buffer.
   logic          credit_ok;
   logic          send;

   // a credit coming back this cycle may be spent right away
   assign credit_ok = (credits != '0) || tx_credit;

   assign fifo_read = (state == st_loop) && credit_ok && !fifo_empty;
   assign step      = (state == st_burst) && credit_ok;
   assign send      = fifo_read || step;
   assign load      = (state == st_idle) && start &&
                      (mode == mode_burst) && (length != 16'd0);

   ////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      state_next = state;
      case (state)
         st_idle:
         begin
            if (mode == mode_loop)
               state_next = st_loop;
            else if (load)
               state_next = st_burst;
         end
         st_loop:
         begin
            if (mode != mode_loop)
               state_next = st_idle;   // words in flight still leave.
         end
         st_burst:
         begin
            if (step && count_last)
               state_next = st_done;
         end
         st_done:
            state_next = st_idle;
         default:
            state_next = st_idle;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // state, credits and to-host port
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         state     <= st_idle;
         credits   <= cw'(tx_credits);
         tx_valid  <= 1'b0;
         interrupt <= 1'b0;
      end
      else
      begin
         state     <= state_next;
         tx_valid  <= send;
         interrupt <= (state == st_done);   // one cycle after the last word.
         case ({tx_credit, send})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;   // none, or one in and one out.
         endcase
      end
   end

   // payload register qualified by tx_valid
   always_ff @(posedge clock)
   begin
      if (fifo_read)
         tx_data <= fifo_data;
      else if (step)
         tx_data <= count_value;
   end

endmodule

// ==== source/fifo_bridge_top.sv ====
// host stream bridge without the PCIe core; credit flow control both ways.
// after reset the host owns rx_depth credits and this design owns tx_credits.
module fifo_bridge_top
#(
   parameter int rx_depth   = 16,   // host-word FIFO depth, power of two.
   parameter int tx_credits = 8     // host receive buffer size.
)
(
   input  logic                                  clock,
   input  logic                                  rst,
   // register write port
   input  logic                                  pio_valid,
   input  logic [fifo_bridge_pkg::addr_width-1:0] pio_address,
   input  logic [fifo_bridge_pkg::data_width-1:0] pio_data,
   // from host
   input  logic                                  rx_valid,
   input  logic [fifo_bridge_pkg::data_width-1:0] rx_data,
   output logic                                  rx_credit,
   // to host
   output logic                                  tx_valid,
   output logic [fifo_bridge_pkg::data_width-1:0] tx_data,
   input  logic                                  tx_credit,
   output logic                                  interrupt,
   output logic [3:0]                            led
);
   import fifo_bridge_pkg::*;

   ////////////////////////////////////////////////////////////
   // internal wires
   ////////////////////////////////////////////////////////////
   mode_t                 mode;
   logic                  start;
   logic [31:0]           seed;
   logic [15:0]           length;
   logic [data_width-1:0] fifo_data;
   logic                  fifo_empty;
   logic                  fifo_read;
   logic [data_width-1:0] count_value;
   logic                  count_last;
   logic                  load;
   logic                  step;

   pio_regs pio_regs_inst
   (
      .clock       (clock),
      .rst         (rst),
      .pio_valid   (pio_valid),
      .pio_address (pio_address),
      .pio_data    (pio_word_t'(pio_data)),   // decoded per address inside.
      .led         (led),
      .mode        (mode),
      .start       (start),
      .seed        (seed),
      .length      (length)
   );

   stream_fifo #(
      .rx_depth (rx_depth)
   ) stream_fifo_inst
   (
      .clock      (clock),
      .rst        (rst),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .fifo_read  (fifo_read),
      .fifo_data  (fifo_data),
      .fifo_empty (fifo_empty),
      .rx_credit  (rx_credit)
   );

   word_counter word_counter_inst
   (
      .clock       (clock),
      .rst         (rst),
      .load        (load),
      .seed        (seed),
      .length      (length),
      .step        (step),
      .count_value (count_value),
      .count_last  (count_last)
   );

   stream_ctrl #(
      .tx_credits (tx_credits)
   ) stream_ctrl_inst
   (
      .clock       (clock),
      .rst         (rst),
      .mode        (mode),
      .start       (start),
      .length      (length),
      .fifo_data   (fifo_data),
      .fifo_empty  (fifo_empty),
      .count_value (count_value),
      .count_last  (count_last),
      .tx_credit   (tx_credit),
      .fifo_read   (fifo_read),
      .load        (load),
      .step        (step),
      .tx_valid    (tx_valid),
      .tx_data     (tx_data),
      .interrupt   (interrupt)
   );

endmodule

// ==== verification/fifo_bridge_tb.sv ====
// drives the bridge with a credit-honouring host model and checks every to-host word.
// stops at the first mismatch; fixed seed, so every run is the same.
module fifo_bridge_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import fifo_bridge_pkg::*;

   localparam int rx_depth   = 16;
   localparam int tx_credits = 8;
   localparam int loop_words = 200;

   logic                  clock;
   logic                  rst;
   logic                  pio_valid;
   logic [addr_width-1:0] pio_address;
   logic [data_width-1:0] pio_data;
   logic                  rx_valid;
   logic [data_width-1:0] rx_data;
   logic                  rx_credit;
   logic                  tx_valid;
   logic [data_width-1:0] tx_data;
   logic                  tx_credit;
   logic                  interrupt;
   logic [3:0]            led;

   logic [data_width-1:0] send_q[$];     // words the host still has to send.
   logic [data_width-1:0] expect_q[$];   // words the host should receive.
   int          rx_cred = rx_depth;      // host-side view of FIFO space.
   int          rx_credit_count = 0;
   int          tx_recv = 0;             // tx_valid cycles seen.
   int          tx_ret = 0;              // tx credits handed back.
   int          irq_count = 0;
   int          total_words = 0;
   int          hold_snapshot;
   logic        irq_prev = 1'b0;
   logic        tx_prev = 1'b0;          // tx_valid one cycle back.
   logic        hold_credit = 1'b0;
   logic [31:0] burst_seed;
   logic [15:0] burst_len;

   fifo_bridge_top #(
      .rx_depth   (rx_depth),
      .tx_credits (tx_credits)
   ) fifo_bridge_top_inst
   (
      .clock       (clock),
      .rst         (rst),
      .pio_valid   (pio_valid),
      .pio_address (pio_address),
      .pio_data    (pio_data),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data),
      .rx_credit   (rx_credit),
      .tx_valid    (tx_valid),
      .tx_data     (tx_data),
      .tx_credit   (tx_credit),
      .interrupt   (interrupt),
      .led         (led)
   );

   initial
   begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////
   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Simulation failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // expected to-host words; one echoed word, or a whole counting burst
   function automatic void predict_words(input logic burst, input logic [63:0] word,
                                         input logic [31:0] seed, input int count);
      logic [31:0] value;
      if (!burst)
      begin
         expect_q.push_back(word);
      end
      else
      begin
         for (int i = 0; i < count; i++)
         begin
            value = seed + 32'(i);              // 32-bit wrap.
            expect_q.push_back({32'd0, value});
         end
      end
   endfunction

   function automatic logic [63:0] ctrl_word(input logic [3:0] led_value,
                                             input logic [1:0] mode_value,
                                             input logic start_bit);
      return {55'd0, start_bit, 2'b00, mode_value, led_value};
   endfunction

   function automatic logic [63:0] burst_setup_word(input logic [31:0] seed,
                                                    input logic [15:0] length);
      return {16'd0, length, seed};
   endfunction

   task automatic write_reg(input logic [addr_width-1:0] address, input logic [63:0] data);
      @(negedge clock);
      pio_valid   = 1'b1;
      pio_address = address;
      pio_data    = data;
      @(negedge clock);
      pio_valid = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // host model with credits both ways
   ////////////////////////////////////////////////////////////
   always @(negedge clock)
   begin
      if (rst)
      begin
         rx_valid  = 1'b0;
         tx_credit = 1'b0;
      end
      else
      begin
         if (rx_credit)
         begin
            rx_cred++;
            rx_credit_count++;
         end
         if (tx_valid)
            tx_recv++;
         check_value(64'(tx_recv <= tx_credits + tx_ret), 64'd1, "tx_valid beyond credits");
         if (send_q.size() > 0 && rx_cred > 0 && ($urandom() % 4) != 0)
         begin
            rx_data  = send_q.pop_front();
            rx_valid = 1'b1;
            rx_cred--;
            predict_words(1'b0, rx_data, 32'd0, 1);
         end
         else
            rx_valid = 1'b0;
         if (!hold_credit && tx_recv > tx_ret && ($urandom() % 2) == 1)
         begin
            tx_credit = 1'b1;
            tx_ret++;
         end
         else
            tx_credit = 1'b0;
      end
   end

   // compare to-host words and watch the interrupt
   always @(negedge clock)
   begin
      if (!rst)
      begin
         if (tx_valid)
         begin
            check_value(64'(expect_q.size() > 0), 64'd1, "tx word with nothing expected");
            check_value(tx_data, expect_q.pop_front(), "tx word");
         end
         if (interrupt)
         begin
            check_value(64'(irq_prev), 64'd0, "interrupt longer than one cycle");
            check_value(64'(expect_q.size()), 64'd0, "interrupt before last burst word");
            check_value(64'(tx_prev), 64'd1, "interrupt late after the last burst word");
            irq_count++;
         end
         irq_prev = interrupt;
         tx_prev  = tx_valid;
      end
   end

   initial
   begin
      wait (total_words > 0);
      #(20 * total_words * 10 + 5000);
      $display("timeout: the run did not finish in time (%0d words planned)", total_words);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      rst         = 1'b1;
      pio_valid   = 1'b0;
      pio_address = '0;
      pio_data    = '0;
      rx_valid    = 1'b0;
      rx_data     = '0;
      tx_credit   = 1'b0;
      void'($urandom(7902));
      burst_seed  = $urandom();
      burst_len   = 16'(20 + ($urandom() % 41));
      total_words = loop_words + int'(burst_len);

      repeat (10) @(posedge clock);
      @(negedge clock);
      check_value(64'(tx_valid), 64'd0, "tx_valid after reset");
      check_value(64'(rx_credit), 64'd0, "rx_credit after reset");
      check_value(64'(interrupt), 64'd0, "interrupt after reset");
      check_value(64'(led), 64'h5, "led after reset");
      rst = 1'b0;

      // led follows control writes only
      write_reg(addr_ctrl, ctrl_word(4'hA, mode_idle, 1'b0));
      check_value(64'(led), 64'hA, "led after control write");
      write_reg(addr_burst, burst_setup_word(32'h0000_0003, 16'd0));
      check_value(64'(led), 64'hA, "led after burst setup write");

      // loop mode with a credit hold in the middle
      write_reg(addr_ctrl, ctrl_word(4'h9, mode_loop, 1'b0));
      @(posedge clock);
      for (int i = 0; i < loop_words; i++)
         send_q.push_back({$urandom(), $urandom()});
      while (send_q.size() > loop_words / 2)
         @(posedge clock);
      hold_credit = 1'b1;
      repeat (30) @(posedge clock);
      hold_snapshot = tx_recv;
      repeat (70) @(posedge clock);
      check_value(64'(tx_recv), 64'(hold_snapshot), "output moved without credits");
      check_value(64'(tx_recv - tx_ret), 64'(tx_credits), "credits left unused on hold");
      hold_credit = 1'b0;
      while (send_q.size() > 0 || expect_q.size() > 0)
         @(posedge clock);
      repeat (5) @(posedge clock);
      check_value(64'(rx_credit_count), 64'(loop_words), "rx_credit pulses");
      check_value(64'(rx_cred), 64'(rx_depth), "host rx credits after loop");
      check_value(64'(tx_recv), 64'(loop_words), "words echoed in loop mode");
      check_value(64'(irq_count), 64'd0, "interrupt in loop mode");

      // burst mode
      write_reg(addr_ctrl, ctrl_word(4'h9, mode_idle, 1'b0));
      write_reg(addr_burst, burst_setup_word(burst_seed, burst_len));
      check_value(64'(led), 64'h9, "led after burst setup write");
      @(posedge clock);
      predict_words(1'b1, 64'd0, burst_seed, int'(burst_len));
      write_reg(addr_ctrl, ctrl_word(4'hC, mode_burst, 1'b1));
      check_value(64'(led), 64'hC, "led after burst start");
      while (expect_q.size() > 0 || irq_count == 0)
         @(posedge clock);
      repeat (50) @(posedge clock);   // tx_valid must stay low here.
      check_value(64'(irq_count), 64'd1, "interrupt pulses per burst");
      check_value(64'(tx_recv), 64'(total_words), "total words to host");

      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== filelist.f ====
source/fifo_bridge_pkg.sv
source/pio_regs.sv
source/stream_fifo.sv
source/word_counter.sv
source/stream_ctrl.sv
source/fifo_bridge_top.sv
verification/fifo_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the stream bridge testbench with Verilator and runs it.
# Exit status is 0 only when the log holds no failure report.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=fifo_bridge_tb
LOG=sim.log

verilator --binary --timing -Wno-fatal \
   -f filelist.f \
   --top-module "$TOP" \
   --Mdir "$BUILD_DIR" \
   -o "sim_$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "ERROR: Verilator build failed with status $build_status"
   exit 1
fi

"./$BUILD_DIR/sim_$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   echo "RESULT: testbench reported a failure (see $LOG)"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "RESULT: simulator exited with status $run_status"
   exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
   echo "RESULT: run ended without a pass report"
   exit 1
fi

echo "RESULT: pass"
exit 0
